// File: include/forth_settings.svh
`ifndef FORTH_SETTINGS_SVH
`define FORTH_SETTINGS_SVH

// Datapath width of operands, results and registers
`define DATA_WIDTH 16

// Size of the general register file
`define REG_COUNT 16

// Enough bits to name every register
`define REG_IDX_WIDTH 4

`endif

// File: verilog/forthPkg.sv
`include "forth_settings.svh"

package forthPkg;

	typedef logic [`DATA_WIDTH-1:0] dataWord;
	typedef logic [`REG_IDX_WIDTH-1:0] regIdx;

	typedef enum logic [3:0] {
		opMov = 4'd0, // Copy of operand B
		opAdd = 4'd1,
		opSub = 4'd2,
		opMul = 4'd3, // Low half kept, high half feeds parity
		opOr = 4'd4,
		opAnd = 4'd5,
		opXor = 4'd6,
		opSl = 4'd7, // Shift left, last bit out into carry
		opSr = 4'd8,
		opSra = 4'd9, // Sign bit kept
		opRot = 4'd10, // Rotate right
		opBit = 4'd11, // Test single bit
		opSet = 4'd12,
		opClr = 4'd13,
		opCmp = 4'd14, // Subtract without write-back
		opSex = 4'd15 // Sign extend from bit position
	} aluOp;

	typedef struct packed {
		aluOp op;
		regIdx srcA;
		regIdx srcB;
		regIdx dest;
	} aluCmd;

	typedef struct packed {
		regIdx idx;
		dataWord value;
	} regLoad;

	typedef struct packed {
		logic sign;
		logic carry;
		logic zero;
		logic parity; // Overflow or MUL high half on arithmetic ops
	} aluFlags;

	typedef struct packed {
		dataWord value;
		aluFlags flags;
	} aluOut;

	// Only these three touch the carry flag
	function automatic logic producesCarry(aluOp op);
		return (op == opAdd) || (op == opSub) || (op == opSl);
	endfunction

	// Compare leaves its destination alone
	function automatic logic writesBack(aluOp op);
		return op != opCmp;
	endfunction

endpackage

// File: verilog/alu.sv
`timescale 1ns/10ps
`include "forth_settings.svh"

module alu (
	input forthPkg::aluOp op,
	input logic signed [`DATA_WIDTH-1:0] argA,
	input logic signed [`DATA_WIDTH-1:0] argB,
	output forthPkg::dataWord result,
	output forthPkg::aluFlags rawFlags,
	output logic carryValid
);
	import forthPkg::*;

	localparam int dataBits = `DATA_WIDTH;
	localparam int shiftBits = $clog2(`DATA_WIDTH);

	logic [shiftBits-1:0] amount; // Shift and bit position
	dataWord bitMask;
	dataWord sexMask;
	logic signed [2*dataBits-1:0] product;
	logic sexBit;
	logic carryOut;
	logic arithmetic;
	logic overflow;

	assign amount = argB[shiftBits-1:0];
	assign bitMask = dataWord'(1) << amount;
	assign sexMask = {dataBits{1'b1}} << amount; // Bits at and above the position
	assign product = argA * argB; // Full signed product
	assign sexBit = |(argA & bitMask);

	always_comb begin
		result = argB;
		carryOut = 1'b0;
		arithmetic = 1'b0;
		case (op)
			opMov: result = argB;
			opAdd: begin
				{carryOut, result} = {1'b0, argA} + {1'b0, argB};
				arithmetic = 1'b1;
			end
			opSub: begin
				{carryOut, result} = {1'b0, argA} - {1'b0, argB}; // Carry is the borrow
				arithmetic = 1'b1;
			end
			opMul: result = product[dataBits-1:0];
			opOr: result = argA | argB;
			opAnd: result = argA & argB;
			opXor: result = argA ^ argB;
			opSl: {carryOut, result} = {1'b0, argA} << amount;
			opSr: result = $unsigned(argA) >> amount;
			opSra: result = argA >>> amount;
			opRot: begin
				// A shift by the full width gives zero, so ROT by 0 is a copy
				result = ($unsigned(argA) >> amount) |
					($unsigned(argA) << (dataBits - amount));
			end
			opBit: result = argA & bitMask;
			opSet: result = argA | bitMask;
			opClr: result = argA & ~bitMask;
			opCmp: begin
				result = argA - argB;
				arithmetic = 1'b1;
			end
			opSex: begin
				if (sexBit) begin
					result = argA | sexMask;
				end else begin
					result = argA & ~sexMask;
				end
				arithmetic = 1'b1;
			end
		endcase
	end

	// Same overflow term for every arithmetic op, SUB and SEX included
	assign overflow = (argA[dataBits-1] & argB[dataBits-1] & ~result[dataBits-1]) |
		(~argA[dataBits-1] & ~argB[dataBits-1] & result[dataBits-1]);

	always_comb begin
		rawFlags.sign = result[dataBits-1];
		rawFlags.carry = carryOut;
		rawFlags.zero = (result == '0);
		if (op == opMul) begin
			rawFlags.parity = |product[2*dataBits-1:dataBits]; // Any bit in upper half
		end else if (arithmetic) begin
			rawFlags.parity = overflow;
		end else begin
			rawFlags.parity = result[0];
		end
	end

	assign carryValid = producesCarry(op);

endmodule

// File: verilog/registerFile.sv
`timescale 1ns/10ps
`include "forth_settings.svh"

module registerFile (
	input logic clk,
	input logic rstN,
	input forthPkg::regIdx rdIdxA,
	input forthPkg::regIdx rdIdxB,
	output forthPkg::dataWord rdDataA,
	output forthPkg::dataWord rdDataB,
	input logic wrEn,
	input forthPkg::regIdx wrIdx,
	input forthPkg::dataWord wrData
);
	import forthPkg::*;

	dataWord regs [`REG_COUNT];

	// Reads see the array directly, so a write is visible the next cycle
	assign rdDataA = regs[rdIdxA];
	assign rdDataB = regs[rdIdxB];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0; // Every register reads zero after reset
			end
		end else if (wrEn) begin
			regs[wrIdx] <= wrData;
		end
	end

endmodule

// File: verilog/executeStage.sv
`timescale 1ns/10ps

module executeStage (
	input logic clk,
	input logic rstN,
	input logic cmdValid,
	input forthPkg::aluCmd cmd,
	input logic loadValid,
	input forthPkg::regLoad load,
	output forthPkg::regIdx rdIdxA,
	output forthPkg::regIdx rdIdxB,
	input forthPkg::dataWord rdDataA,
	input forthPkg::dataWord rdDataB,
	output forthPkg::aluOp aluOpSel,
	output forthPkg::dataWord aluArgA,
	output forthPkg::dataWord aluArgB,
	input forthPkg::dataWord aluResult,
	input forthPkg::aluFlags aluRawFlags,
	input logic aluCarryValid,
	output logic wrEn,
	output forthPkg::regIdx wrIdx,
	output forthPkg::dataWord wrData,
	output logic resValid,
	output forthPkg::aluOut res,
	output forthPkg::aluFlags flags
);
	import forthPkg::*;

	aluCmd cmdReg; // Command in its execute cycle
	logic cmdPending;
	logic wbEn; // Write-back request before arbitration
	aluFlags flagReg;
	aluFlags mergedFlags;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			cmdPending <= 1'b0;
		end else begin
			cmdPending <= cmdValid;
		end
	end

	always_ff @(posedge clk) begin
		if (cmdValid) begin
			cmdReg <= cmd;
		end
	end

	// Operands come straight from the register file
	assign rdIdxA = cmdReg.srcA;
	assign rdIdxB = cmdReg.srcB;
	assign aluOpSel = cmdReg.op;
	assign aluArgA = rdDataA;
	assign aluArgB = rdDataB;

	assign wbEn = cmdPending && writesBack(cmdReg.op);

	// One write port, and a load always owns it
	// A write-back that meets a load in the same cycle is lost
	assign wrEn = loadValid || wbEn;
	assign wrIdx = loadValid ? load.idx : cmdReg.dest;
	assign wrData = loadValid ? load.value : aluResult;

	always_comb begin
		mergedFlags = aluRawFlags;
		if (!aluCarryValid) begin
			mergedFlags.carry = flagReg.carry; // Held carry survives non-carry ops
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			resValid <= 1'b0;
			res <= '0;
			flagReg <= '0;
		end else begin
			resValid <= cmdPending;
			if (cmdPending) begin
				res.value <= aluResult;
				res.flags <= aluRawFlags; // Raw flags, not the merged word
				flagReg <= mergedFlags;
			end
		end
	end

	assign flags = flagReg;

endmodule

// File: verilog/aluCore.sv
`timescale 1ns/10ps

module aluCore (
	input logic clk,
	input logic rstN,
	input logic cmdValid,
	input forthPkg::aluCmd cmd,
	input logic loadValid,
	input forthPkg::regLoad load,
	output logic resValid,
	output forthPkg::aluOut res,
	output forthPkg::aluFlags flags
);
	import forthPkg::*;

	regIdx rdIdxA;
	regIdx rdIdxB;
	dataWord rdDataA;
	dataWord rdDataB;
	aluOp aluOpSel;
	dataWord aluArgA;
	dataWord aluArgB;
	dataWord aluResult;
	aluFlags aluRawFlags;
	logic aluCarryValid;
	logic wrEn;
	regIdx wrIdx;
	dataWord wrData;

	registerFile regFile (
		.clk(clk),
		.rstN(rstN),
		.rdIdxA(rdIdxA),
		.rdIdxB(rdIdxB),
		.rdDataA(rdDataA),
		.rdDataB(rdDataB),
		.wrEn(wrEn),
		.wrIdx(wrIdx),
		.wrData(wrData)
	);

	alu aluUnit (
		.op(aluOpSel),
		.argA(aluArgA), // Taken as signed inside the ALU
		.argB(aluArgB),
		.result(aluResult),
		.rawFlags(aluRawFlags),
		.carryValid(aluCarryValid)
	);

	executeStage exec (
		.clk(clk),
		.rstN(rstN),
		.cmdValid(cmdValid),
		.cmd(cmd),
		.loadValid(loadValid),
		.load(load),
		.rdIdxA(rdIdxA),
		.rdIdxB(rdIdxB),
		.rdDataA(rdDataA),
		.rdDataB(rdDataB),
		.aluOpSel(aluOpSel),
		.aluArgA(aluArgA),
		.aluArgB(aluArgB),
		.aluResult(aluResult),
		.aluRawFlags(aluRawFlags),
		.aluCarryValid(aluCarryValid),
		.wrEn(wrEn),
		.wrIdx(wrIdx),
		.wrData(wrData),
		.resValid(resValid),
		.res(res),
		.flags(flags)
	);

endmodule

// File: sim/clockGen.sv
`timescale 1ns/10ps

module clockGen #(
	parameter realtime halfPeriod = 2.0 // 4 ns period
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	always #(halfPeriod) clk = ~clk;

endmodule

// File: sim/aluCore_checker.sv
`timescale 1ns/10ps

module aluCore_checker (
	input logic clk,
	input logic rstN,
	input logic cmdValid,
	input logic cmdPending,
	input forthPkg::aluOp cmdOp,
	input logic loadValid,
	input logic wrEn,
	input logic resValid,
	input forthPkg::aluFlags flags
);
	import forthPkg::*;

	// Result strobe two edges after the command edge
	resultFollowsCmd: assert property (@(posedge clk) disable iff (!rstN)
		cmdValid |-> ##2 resValid)
		else $error("resValid missing after a command");

	noStrayResult: assert property (@(posedge clk) disable iff (!rstN)
		resValid |-> $past(cmdValid, 2))
		else $error("resValid without a command");

	// A compare never writes its destination
	noCmpWrite: assert property (@(posedge clk) disable iff (!rstN)
		(cmdPending && cmdOp == opCmp && !loadValid) |-> !wrEn)
		else $error("write-back enabled for CMP");

	flagsKnown: assert property (@(posedge clk) disable iff (!rstN)
		!$isunknown(flags))
		else $error("flag register holds unknown bits");

endmodule

bind executeStage aluCore_checker protocolCheck (
	.clk(clk),
	.rstN(rstN),
	.cmdValid(cmdValid),
	.cmdPending(cmdPending),
	.cmdOp(cmdReg.op),
	.loadValid(loadValid),
	.wrEn(wrEn),
	.resValid(resValid),
	.flags(flags)
);

// File: sim/aluCore_tb.sv
`timescale 1ns/10ps
`include "forth_settings.svh"

module aluCore_tb;
	import forthPkg::*;

	localparam int waitLimit = 20;

	logic clk;
	logic rstN;
	logic cmdValid;
	aluCmd cmd;
	logic loadValid;
	regLoad load;
	logic resValid;
	aluOut res;
	aluFlags flags;

	dataWord modelRegs [`REG_COUNT];
	aluFlags modelFlags;
	logic [31:0] rngState;

	// Stimulus table, one index per entry
	string entryName[$];
	aluCmd entryCmd[$];
	logic entryLoad[$];
	dataWord entryValA[$];
	dataWord entryValB[$];

	clockGen clkGen (.clk(clk));

	aluCore UUT (
		.clk(clk),
		.rstN(rstN),
		.cmdValid(cmdValid),
		.cmd(cmd),
		.loadValid(loadValid),
		.load(load),
		.resValid(resValid),
		.res(res),
		.flags(flags)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic aluCmd makeCmd(aluOp op, int a, int b, int d);
		aluCmd c;
		c.op = op;
		c.srcA = regIdx'(a);
		c.srcB = regIdx'(b);
		c.dest = regIdx'(d);
		return c;
	endfunction

	// Reference model of one ALU operation
	function automatic aluOut modelAlu(aluOp op, dataWord a, dataWord b);
		logic [3:0] amt;
		logic [16:0] wide;
		logic signed [15:0] sa;
		logic signed [15:0] sb;
		logic signed [31:0] prod;
		logic [31:0] doubled;
		dataWord lowMask;
		dataWord r;
		logic c;
		logic ovf;
		aluOut o;
		amt = b[3:0];
		sa = a;
		sb = b;
		prod = sa * sb;
		doubled = {a, a} >> amt;
		lowMask = (16'h1 << amt) - 16'h1; // Bits below the position
		c = 1'b0;
		r = '0;
		case (op)
			opMov: r = b;
			opAdd: begin
				wide = {1'b0, a} + {1'b0, b};
				r = wide[15:0];
				c = wide[16];
			end
			opSub: begin
				wide = {1'b0, a} - {1'b0, b};
				r = wide[15:0];
				c = wide[16];
			end
			opMul: r = prod[15:0];
			opOr: r = a | b;
			opAnd: r = a & b;
			opXor: r = a ^ b;
			opSl: begin
				wide = {1'b0, a} << amt;
				r = wide[15:0];
				c = wide[16];
			end
			opSr: r = a >> amt;
			opSra: r = sa >>> amt;
			opRot: r = doubled[15:0];
			opBit: r = a & (16'h1 << amt);
			opSet: r = a | (16'h1 << amt);
			opClr: r = a & ~(16'h1 << amt);
			opCmp: r = a - b;
			opSex: r = a[amt] ? (a | ~lowMask) : (a & lowMask);
		endcase
		ovf = (a[15] & b[15] & ~r[15]) | (~a[15] & ~b[15] & r[15]);
		o.value = r;
		o.flags.sign = r[15];
		o.flags.carry = c;
		o.flags.zero = (r == '0);
		if (op == opMul) begin
			o.flags.parity = |prod[31:16];
		end else if (op inside {opAdd, opSub, opCmp, opSex}) begin
			o.flags.parity = ovf;
		end else begin
			o.flags.parity = r[0];
		end
		return o;
	endfunction

	task automatic failRun(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic checkValue(input string name, input logic [19:0] expected,
		input logic [19:0] actual);
		assert (actual === expected) else begin
			failRun($sformatf("FAILED %s expected %h actual %h", name, expected, actual));
		end
	endtask

	task automatic waitResult(input string name);
		int cnt;
		cnt = 0;
		while (!resValid && cnt < waitLimit) begin
			@(posedge clk);
			#1;
			cnt++;
		end
		if (!resValid) begin
			failRun($sformatf("Timeout while waiting for the result of %s", name));
		end
	endtask

	task automatic loadReg(input regIdx idx, input dataWord value);
		load.idx = idx;
		load.value = value;
		loadValid = 1'b1;
		@(posedge clk);
		#1;
		loadValid = 1'b0;
		modelRegs[idx] = value;
	endtask

	// Advance the model by one command
	task automatic commitModel(input aluCmd c, output aluOut expOut, output aluFlags expFlags);
		expOut = modelAlu(c.op, modelRegs[c.srcA], modelRegs[c.srcB]);
		expFlags = expOut.flags;
		if (!(c.op inside {opAdd, opSub, opSl})) begin
			expFlags.carry = modelFlags.carry;
		end
		modelFlags = expFlags;
		if (c.op != opCmp) begin
			modelRegs[c.dest] = expOut.value;
		end
	endtask

	task automatic checkOutputs(input string name, input aluOut expOut, input aluFlags expFlags);
		checkValue(name, expOut, res);
		checkValue({name, " flags"}, 20'(expFlags), 20'(flags));
	endtask

	task automatic runCmd(input string name, input aluCmd c);
		aluOut expOut;
		aluFlags expFlags;
		commitModel(c, expOut, expFlags);
		cmd = c;
		cmdValid = 1'b1;
		@(posedge clk);
		#1;
		cmdValid = 1'b0;
		waitResult(name);
		checkOutputs(name, expOut, expFlags);
	endtask

	task automatic addEntry(input string name, input aluCmd c, input logic useLoad,
		input dataWord va, input dataWord vb);
		entryName.push_back(name);
		entryCmd.push_back(c);
		entryLoad.push_back(useLoad);
		entryValA.push_back(va);
		entryValB.push_back(vb);
	endtask

	initial begin
		aluOut expFirst;
		aluOut expSecond;
		aluFlags flagsFirst;
		aluFlags flagsSecond;
		aluCmd c;
		rstN = 1'b0;
		cmdValid = 1'b0;
		cmd = '0;
		loadValid = 1'b0;
		load = '0;
		rngState = 32'h705d_f9cc;
		modelFlags = '0;
		for (int i = 0; i < `REG_COUNT; i++) begin
			modelRegs[i] = '0;
		end
		repeat (8) @(posedge clk);
		#1;
		rstN = 1'b1;

		checkValue("resetResValid", 20'(0), 20'(resValid));
		checkValue("resetRes", 20'(0), res);
		checkValue("resetFlags", 20'(0), 20'(flags));
		for (int i = 0; i < `REG_COUNT; i++) begin
			runCmd($sformatf("resetMov%0d", i), makeCmd(opMov, 0, i, i));
		end

		for (int i = 0; i < `REG_COUNT; i++) begin
			rngState = xorshift(rngState);
			loadReg(regIdx'(i), rngState[15:0]);
		end

		addEntry("movBasic", makeCmd(opMov, 1, 2, 3), 1'b0, '0, '0);
		addEntry("addCarry", makeCmd(opAdd, 12, 13, 6), 1'b1, 16'hffff, 16'h0002);
		addEntry("xorCarryHold", makeCmd(opXor, 1, 2, 7), 1'b0, '0, '0);
		addEntry("addPlain", makeCmd(opAdd, 1, 2, 8), 1'b0, '0, '0);
		addEntry("subBorrow", makeCmd(opSub, 12, 13, 9), 1'b1, 16'h0003, 16'h0005);
		addEntry("mulUpper", makeCmd(opMul, 12, 13, 9), 1'b1, 16'h0123, 16'h0456);
		addEntry("orBasic", makeCmd(opOr, 3, 4, 5), 1'b0, '0, '0);
		addEntry("andBasic", makeCmd(opAnd, 5, 6, 7), 1'b0, '0, '0);
		addEntry("slCarry", makeCmd(opSl, 12, 13, 8), 1'b1, 16'h8001, 16'h0001);
		addEntry("srBasic", makeCmd(opSr, 12, 13, 8), 1'b1, 16'hf0f0, 16'h0004);
		addEntry("sraNegative", makeCmd(opSra, 12, 13, 8), 1'b1, 16'h8000, 16'h0003);
		addEntry("rotZero", makeCmd(opRot, 12, 13, 9), 1'b1, 16'h1234, 16'h0000);
		addEntry("rotFour", makeCmd(opRot, 12, 13, 9), 1'b1, 16'h1234, 16'h0004);
		addEntry("bitTest", makeCmd(opBit, 12, 13, 9), 1'b1, 16'h00f0, 16'h0005);
		addEntry("setBit", makeCmd(opSet, 12, 13, 9), 1'b1, 16'h0000, 16'h000f);
		addEntry("clrBit", makeCmd(opClr, 12, 13, 9), 1'b1, 16'hffff, 16'h0000);
		addEntry("cmpKeep", makeCmd(opCmp, 1, 2, 10), 1'b0, '0, '0);
		addEntry("movAfterCmp", makeCmd(opMov, 0, 10, 11), 1'b0, '0, '0);
		addEntry("sexNegative", makeCmd(opSex, 12, 13, 14), 1'b1, 16'h0080, 16'h0007);
		addEntry("sexPositive", makeCmd(opSex, 12, 13, 14), 1'b1, 16'hff70, 16'h0007);
		addEntry("sexRandom", makeCmd(opSex, 4, 5, 15), 1'b0, '0, '0);

		for (int i = 0; i < entryName.size(); i++) begin
			if (entryLoad[i]) begin
				loadReg(entryCmd[i].srcA, entryValA[i]);
				loadReg(entryCmd[i].srcB, entryValB[i]);
			end
			runCmd(entryName[i], entryCmd[i]);
		end

		// Second command reads the first one's destination
		commitModel(makeCmd(opAdd, 1, 2, 3), expFirst, flagsFirst);
		commitModel(makeCmd(opAdd, 3, 3, 4), expSecond, flagsSecond);
		cmd = makeCmd(opAdd, 1, 2, 3);
		cmdValid = 1'b1;
		@(posedge clk);
		#1;
		cmd = makeCmd(opAdd, 3, 3, 4);
		@(posedge clk);
		#1;
		cmdValid = 1'b0;
		waitResult("backToBackFirst");
		checkOutputs("backToBackFirst", expFirst, flagsFirst);
		@(posedge clk);
		#1;
		checkValue("backToBackStrobe", 20'(1), 20'(resValid));
		checkOutputs("backToBackSecond", expSecond, flagsSecond);

		// Load meets the write-back of the same register
		c = makeCmd(opOr, 5, 6, 7);
		commitModel(c, expFirst, flagsFirst);
		cmd = c;
		cmdValid = 1'b1;
		@(posedge clk);
		#1;
		cmdValid = 1'b0;
		loadReg(regIdx'(7), 16'hbeef);
		waitResult("loadCollision");
		checkOutputs("loadCollision", expFirst, flagsFirst);
		runCmd("movAfterCollision", makeCmd(opMov, 0, 7, 8));

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// File: sim.f
+incdir+include
verilog/forthPkg.sv
verilog/alu.sv
verilog/registerFile.sv
verilog/executeStage.sv
verilog/aluCore.sv
sim/clockGen.sv
sim/aluCore_checker.sv
sim/aluCore_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = aluCore_tb
FILELIST = sim.f
BUILDDIR = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILDDIR)

run: compile
	-./$(BUILDDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "SIMULATION PASSED" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILDDIR) $(LOG)
